// File: Makefile
# Verilator build and run for the mesh node testbench

VERILATOR ?= verilator
TOP       ?= mesh_node_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep '\.sv$$' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "^PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/mesh_node.sv
// Mesh router node top level
`timescale 1ns/1ps

module mesh_node (
    input  logic                clk,
    input  logic                rst_n,
    // Configuration, four-phase
    input  logic                cfg_req_i,
    input  mesh_pkg::cfg_addr_e cfg_addr_i,
    input  mesh_pkg::node_id_t  cfg_wdata_i,
    output logic                cfg_ack_o,
    // Inputs, A local injection and the two links
    input  logic                a_valid_i,
    output logic                a_ready_o,
    input  pkt_pkg::pkt_t       a_pkt_i,
    input  logic                cx_valid_i,
    output logic                cx_ready_o,
    input  pkt_pkg::pkt_t       cx_pkt_i,
    input  logic                cy_valid_i,
    output logic                cy_ready_o,
    input  pkt_pkg::pkt_t       cy_pkt_i,
    // Outputs
    output logic                x_valid_o,
    input  logic                x_ready_i,
    output pkt_pkg::pkt_t       x_pkt_o,
    output logic                y_valid_o,
    input  logic                y_ready_i,
    output pkt_pkg::pkt_t       y_pkt_o,
    output logic                b_valid_o,
    input  logic                b_ready_i,
    output pkt_pkg::pkt_t       b_pkt_o
);

    import mesh_pkg::*;
    import pkt_pkg::*;

    node_id_t node_id;
    node_id_t fault_node;
    logic     fault_en;

    // Per-source vectors, index A=0, CX=1, CY=2
    logic   [NUM_SRC-1:0] in_valid, in_ready;
    pkt_t   [NUM_SRC-1:0] in_pkt;
    logic   [NUM_SRC-1:0] slot_valid, slot_pop, slot_qos;
    pkt_t   [NUM_SRC-1:0] slot_pkt;
    route_e               route [NUM_SRC];
    logic   [NUM_SRC-1:0] req_x, req_y, req_b;
    logic   [NUM_SRC-1:0] gnt_x, gnt_y, gnt_b;

    node_cfg u_cfg (
        .clk, .rst_n, .cfg_req_i, .cfg_addr_i, .cfg_wdata_i, .cfg_ack_o,
        .node_id_o(node_id), .fault_en_o(fault_en), .fault_node_o(fault_node)
    );

    assign in_valid = {cy_valid_i, cx_valid_i, a_valid_i};
    assign in_pkt   = {cy_pkt_i, cx_pkt_i, a_pkt_i};
    assign a_ready_o  = in_ready[0];
    assign cx_ready_o = in_ready[1];
    assign cy_ready_o = in_ready[2];

    // ========================================
    // Input slots and route stages
    // ========================================
    for (genvar s = 0; s < NUM_SRC; s++) begin : g_in
        pkt_slot u_slot (
            .clk, .rst_n,
            .in_valid_i(in_valid[s]), .in_ready_o(in_ready[s]), .in_pkt_i(in_pkt[s]),
            .out_valid_o(slot_valid[s]), .pop_i(slot_pop[s]), .out_pkt_o(slot_pkt[s])
        );
        route_calc #(.INJECT(s == 0)) u_route (          // Two-hop only for A
            .valid_i(slot_valid[s]), .pkt_i(slot_pkt[s]), .node_id_i(node_id),
            .fault_en_i(fault_en), .fault_node_i(fault_node), .route_o(route[s])
        );
        assign req_x[s]    = slot_valid[s] && (route[s] == ROUTE_X);
        assign req_y[s]    = slot_valid[s] && (route[s] == ROUTE_Y);
        assign req_b[s]    = slot_valid[s] && (route[s] == ROUTE_B);
        assign slot_qos[s] = slot_pkt[s].qos;
        // Leaves on any grant, or straight away when discarded
        assign slot_pop[s] = gnt_x[s] | gnt_y[s] | gnt_b[s]
                           | (slot_valid[s] && (route[s] == ROUTE_DROP));
    end

    // ========================================
    // Output ports
    // ========================================
    qos_out_port u_out_x (
        .clk, .rst_n, .req_i(req_x), .qos_i(slot_qos), .pkt_i(slot_pkt), .gnt_o(gnt_x),
        .valid_o(x_valid_o), .ready_i(x_ready_i), .pkt_o(x_pkt_o)
    );
    qos_out_port u_out_y (
        .clk, .rst_n, .req_i(req_y), .qos_i(slot_qos), .pkt_i(slot_pkt), .gnt_o(gnt_y),
        .valid_o(y_valid_o), .ready_i(y_ready_i), .pkt_o(y_pkt_o)
    );
    qos_out_port u_out_b (     // Local ejection
        .clk, .rst_n, .req_i(req_b), .qos_i(slot_qos), .pkt_i(slot_pkt), .gnt_o(gnt_b),
        .valid_o(b_valid_o), .ready_i(b_ready_i), .pkt_o(b_pkt_o)
    );

endmodule

// File: logic/mesh_pkg.sv
// Mesh geometry and configuration types
package mesh_pkg;

    // ========================================
    // Geometry
    // ========================================
    localparam int MESH_DIM = 8;                  // Nodes per row and per column
    localparam int COORD_W  = $clog2(MESH_DIM);   // 3 bits per coordinate

    typedef logic [COORD_W-1:0] coord_t;          // One X or Y coordinate

    // Node address, Y in upper half, X in lower half
    typedef struct packed {
        coord_t y;
        coord_t x;
    } node_id_t;

    // ========================================
    // Configuration port
    // ========================================
    typedef enum logic [1:0] {
        CFG_NODE_ID   = 2'd0,   // Write node identity
        CFG_FAULT_SET = 2'd1,   // Write faulty node, avoidance on
        CFG_FAULT_CLR = 2'd2    // Avoidance off
    } cfg_addr_e;

    // Four-phase handshake states
    typedef enum logic [1:0] {
        CFG_IDLE     = 2'd0,    // Waiting for req
        CFG_ACK      = 2'd1,    // Write done, ack high until req drops
        CFG_WAIT_LOW = 2'd2     // Ack just fell, one quiet cycle
    } cfg_state_e;

endpackage

// File: logic/node_cfg.sv
// Node configuration registers
`timescale 1ns/1ps

module node_cfg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_req_i,
    input  mesh_pkg::cfg_addr_e cfg_addr_i,
    input  mesh_pkg::node_id_t  cfg_wdata_i,
    output logic                cfg_ack_o,
    output mesh_pkg::node_id_t  node_id_o,
    output logic                fault_en_o,
    output mesh_pkg::node_id_t  fault_node_o
);

    import mesh_pkg::*;

    cfg_state_e state_q;
    node_id_t   node_id_q;      // This node's position
    node_id_t   fault_node_q;   // Node to steer around
    logic       fault_en_q;

    // ========================================
    // Four-phase handshake
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CFG_IDLE;
        end else begin
            case (state_q)
                CFG_IDLE:     if (cfg_req_i) state_q <= CFG_ACK;    // Write on this edge
                CFG_ACK:      if (!cfg_req_i) state_q <= CFG_WAIT_LOW;
                CFG_WAIT_LOW: state_q <= CFG_IDLE;                  // Ack seen low before next req
                default:      state_q <= CFG_IDLE;
            endcase
        end
    end

    // Ack rises with the write and falls one edge after req drops
    assign cfg_ack_o = (state_q == CFG_ACK);

    // ========================================
    // Configuration registers
    // ========================================
    // Written only from IDLE, so once per request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            node_id_q    <= '0;
            fault_node_q <= '0;
            fault_en_q   <= 1'b0;
        end else if (state_q == CFG_IDLE && cfg_req_i) begin
            case (cfg_addr_i)
                CFG_NODE_ID: begin
                    node_id_q <= cfg_wdata_i;
                end
                CFG_FAULT_SET: begin
                    fault_node_q <= cfg_wdata_i;   // Avoidance armed together with address
                    fault_en_q   <= 1'b1;
                end
                CFG_FAULT_CLR: begin
                    fault_en_q <= 1'b0;            // Keep old address, just disarm
                end
                default: ;                         // Unused opcode, handshake only
            endcase
        end
    end

    assign node_id_o    = node_id_q;
    assign fault_en_o   = fault_en_q;
    assign fault_node_o = fault_node_q;

endmodule

// File: logic/pkt_pkg.sv
// Packet layout and route decision types
package pkt_pkg;

    // ========================================
    // Packet format
    // ========================================
    localparam int DATA_W = 8;    // Payload byte
    localparam int PKT_W  = 23;   // type + qos + src + tgt + data

    localparam int NUM_SRC = 3;   // Requesters per output: A=0, CX=1, CY=2

    // Only unicast is routed, the rest is recognised and discarded
    typedef enum logic [1:0] {
        PKT_UNICAST   = 2'd0,
        PKT_MULTICAST = 2'd1,
        PKT_BROADCAST = 2'd2
    } pkt_type_e;

    // Field order from the MSB down
    typedef struct packed {
        pkt_type_e          ptype;   // [22:21]
        logic               qos;     // [20] high priority
        mesh_pkg::node_id_t src;     // [19:14]
        mesh_pkg::node_id_t tgt;     // [13:8]
        logic [DATA_W-1:0]  data;    // [7:0]
    } pkt_t;

    // ========================================
    // Route decision
    // ========================================
    typedef enum logic [1:0] {
        ROUTE_X    = 2'd0,   // Row link
        ROUTE_Y    = 2'd1,   // Column link
        ROUTE_B    = 2'd2,   // Local ejection
        ROUTE_DROP = 2'd3    // Discard, never reaches an output
    } route_e;

endpackage

// File: logic/pkt_slot.sv
// One-entry packet input slot
`timescale 1ns/1ps

module pkt_slot (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid_i,
    output logic          in_ready_o,
    input  pkt_pkg::pkt_t in_pkt_i,
    output logic          out_valid_o,
    input  logic          pop_i,        // Held packet leaves this cycle
    output pkt_pkg::pkt_t out_pkt_o
);

    logic          full_q;
    pkt_pkg::pkt_t pkt_q;    // Held packet
    logic          push;

    // Ready when empty or emptied this cycle so back-to-back transfers work
    assign in_ready_o = ~full_q | pop_i;
    assign push       = in_valid_i & in_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else begin
            full_q <= push | (full_q & ~pop_i);   // Refill wins over pop
        end
    end

    always_ff @(posedge clk) begin
        if (push) pkt_q <= in_pkt_i;   // Capture on accept
    end

    assign out_valid_o = full_q;
    assign out_pkt_o   = pkt_q;

endmodule

// File: logic/qos_out_port.sv
// QoS round-robin output port
`timescale 1ns/1ps

module qos_out_port (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic          [pkt_pkg::NUM_SRC-1:0] req_i,
    input  logic          [pkt_pkg::NUM_SRC-1:0] qos_i,
    input  pkt_pkg::pkt_t [pkt_pkg::NUM_SRC-1:0] pkt_i,
    output logic          [pkt_pkg::NUM_SRC-1:0] gnt_o,
    output logic                                valid_o,
    input  logic                                ready_i,
    output pkt_pkg::pkt_t                       pkt_o
);

    import pkt_pkg::*;

    localparam int PTR_W = $clog2(NUM_SRC);

    logic [PTR_W-1:0]   ptr_q;      // Round-robin start, shared by both classes
    logic [PTR_W-1:0]   win_idx;
    logic [NUM_SRC-1:0] cand;       // Requesters still in the running
    logic [NUM_SRC-1:0] gnt;
    logic [PKT_W-1:0]   sel_bits;   // Granted packet, flat
    logic               load;
    logic               full_q;
    pkt_t               pkt_q;

    // ========================================
    // Arbitration
    // ========================================
    assign load = ~full_q | ready_i;                        // Empty or draining now
    assign cand = (|(req_i & qos_i)) ? (req_i & qos_i) : req_i;   // High class is absolute

    // First candidate at or after the pointer
    always_comb begin
        int unsigned idx;
        gnt     = '0;
        win_idx = ptr_q;
        for (int k = NUM_SRC - 1; k >= 0; k--) begin    // Descending so nearest wins
            idx = ptr_q + k;
            if (idx >= NUM_SRC) idx = idx - NUM_SRC;     // Wrap
            if (cand[idx]) begin
                gnt     = '0;
                gnt[idx] = 1'b1;
                win_idx = PTR_W'(idx);
            end
        end
    end

    assign gnt_o = load ? gnt : '0;   // No grant while the register is stuck

    // One-hot AND-OR mux
    always_comb begin
        sel_bits = '0;
        for (int k = 0; k < NUM_SRC; k++) begin
            sel_bits = sel_bits | ({PKT_W{gnt[k]}} & pkt_i[k]);
        end
    end

    // ========================================
    // Output register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
            ptr_q  <= '0;
        end else if (|gnt_o) begin
            full_q <= 1'b1;
            ptr_q  <= (win_idx == PTR_W'(NUM_SRC - 1)) ? '0 : win_idx + 1'b1;  // Past winner
        end else if (ready_i) begin
            full_q <= 1'b0;     // Drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (|gnt_o) pkt_q <= pkt_t'(sel_bits);
    end

    assign valid_o = full_q;
    assign pkt_o   = pkt_q;

endmodule

// File: logic/route_calc.sv
// Per-input route decision
`timescale 1ns/1ps

module route_calc #(
    parameter bit INJECT = 1'b0     // 1 for the local injection port
) (
    input  logic               valid_i,
    input  pkt_pkg::pkt_t      pkt_i,
    input  mesh_pkg::node_id_t node_id_i,
    input  logic               fault_en_i,
    input  mesh_pkg::node_id_t fault_node_i,
    output pkt_pkg::route_e    route_o
);

    import mesh_pkg::*;
    import pkt_pkg::*;

    node_id_t first_hop;    // Source row, target column
    node_id_t second_hop;   // Target row, source column
    node_id_t mid_node;     // Intermediate node actually used
    logic     first_bad;

    // ========================================
    // Intermediate node selection
    // ========================================
    assign first_hop.y  = node_id_i.y;
    assign first_hop.x  = pkt_i.tgt.x;
    assign second_hop.y = pkt_i.tgt.y;
    assign second_hop.x = node_id_i.x;

    // At most one faulty node, so the second choice is never checked
    assign first_bad = fault_en_i && (first_hop == fault_node_i);
    assign mid_node  = first_bad ? second_hop : first_hop;

    // ========================================
    // Route decision
    // ========================================
    always_comb begin
        if (!valid_i) begin
            route_o = ROUTE_DROP;                       // Nothing to route
        end else if (pkt_i.ptype != PKT_UNICAST) begin
            route_o = ROUTE_DROP;                       // Multicast and broadcast discarded
        end else if (pkt_i.tgt == node_id_i) begin
            route_o = ROUTE_B;                          // Arrived
        end else if (INJECT) begin
            // Leave along the row only if the intermediate column differs
            if (mid_node.x != node_id_i.x) route_o = ROUTE_X;
            else                           route_o = ROUTE_Y;
        end else begin
            // Transit, X first then Y
            if (pkt_i.tgt.x != node_id_i.x) route_o = ROUTE_X;
            else                            route_o = ROUTE_Y;
        end
    end

endmodule

// File: verif/mesh_node_tb.sv
// Mesh node testbench
`timescale 1ns/1ps

module mesh_node_tb;

    import mesh_pkg::*;
    import pkt_pkg::*;

    localparam int CLK_NS = 100;
    localparam int STALL_LIMIT = 200;              // Cycles a single handshake may take

    logic clk, rst_n, cfg_req_i, cfg_ack_o;
    cfg_addr_e cfg_addr_i;
    node_id_t cfg_wdata_i;
    logic a_valid_i, a_ready_o, cx_valid_i, cx_ready_o, cy_valid_i, cy_ready_o;
    pkt_t a_pkt_i, cx_pkt_i, cy_pkt_i, x_pkt_o, y_pkt_o, b_pkt_o;
    logic x_valid_o, x_ready_i, y_valid_o, y_ready_i, b_valid_o, b_ready_i;

    // Stimulus items from the data file
    string it_name[$], it_chan[$], it_route[$];
    int it_type[$], it_qos[$], it_ord[$], it_mode[$];
    node_id_t it_src[$], it_tgt[$];
    logic [7:0] it_data[$];
    int n_items = 0;

    // Expected traffic per output indexed X=0 Y=1 B=2
    pkt_t exp_pkt[3][$];
    int exp_chan[3][$], exp_ord[3][$], exp_acc[3][$];
    string port_nm[3] = '{"X", "Y", "B"};

    node_id_t m_node = '0;                         // Model copy of the configuration
    node_id_t m_fault = '0;
    logic m_fault_en = 1'b0;
    logic rnd_mode = 1'b0, hold_x = 1'b0, ack_prev = 1'b0;
    logic [15:0] lfsr = 16'd22;
    int test_mode = 0, cyc = 0, err_count = 0, check_count = 0;
    string cur_test = "reset";

    mesh_node dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ========================================
    // Helpers and reference model
    // ========================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // Galois form with taps 16 14 13 11
    endfunction

    function automatic route_e ref_route(input int ch, input pkt_t p);
        node_id_t mid;
        if (p.ptype != PKT_UNICAST) return ROUTE_DROP;
        if (p.tgt == m_node) return ROUTE_B;
        if (ch != 0) return (p.tgt.x != m_node.x) ? ROUTE_X : ROUTE_Y;   // Links go X first
        mid = {m_node.y, p.tgt.x};                 // First choice keeps the source row
        if (m_fault_en && mid == m_fault) mid = {p.tgt.y, m_node.x};
        return (mid.x != m_node.x) ? ROUTE_X : ROUTE_Y;
    endfunction

    function automatic route_e parse_route(input string s);
        if (s == "X") return ROUTE_X;
        if (s == "Y") return ROUTE_Y;
        if (s == "B") return ROUTE_B;
        return ROUTE_DROP;
    endfunction

    // Route decision the DUT made for the packet now held in an input slot
    function automatic route_e slot_route(input int ch);
        case (ch)
            0: return dut.route[0];
            1: return dut.route[1];
            default: return dut.route[2];
        endcase
    endfunction

    task automatic check_route(input route_e exp, input route_e act);
        check_count++;
        if (exp !== act) begin
            $display("Error %s: route expected %s actual %s", cur_test, exp.name(), act.name());
            err_count++;
        end
    endtask

    task automatic check_pkt(input pkt_t exp, input pkt_t act, input string port);
        check_count++;
        if (exp !== act) begin
            $display("Error %s: port %s expected %h actual %h", cur_test, port, exp, act);
            err_count++;
        end
    endtask

    task automatic fail_msg(input string what);
        $display("%s: %s", cur_test, what);
        err_count++;
    endtask

    task automatic load_items();
        int fd, n, ty, q, so, ta, da, od, md;
        string line, nm, ch, rt;
        fd = $fopen("verif/node_input.dat", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;   // Column header
            n = $sscanf(line, "%s %s %d %d %h %h %h %s %d %d",
                        nm, ch, ty, q, so, ta, da, rt, od, md);
            if (n != 10) continue;
            it_name.push_back(nm);
            it_chan.push_back(ch);
            it_type.push_back(ty);
            it_qos.push_back(q);
            it_src.push_back(so[5:0]);
            it_tgt.push_back(ta[5:0]);
            it_data.push_back(da[7:0]);
            it_route.push_back(rt);
            it_ord.push_back(od);
            it_mode.push_back(md);
        end
        $fclose(fd);
        n_items = it_name.size();
    endtask

    // ========================================
    // Output monitor and ready drive
    // ========================================
    task automatic take_output(input int port, input pkt_t act);
        int idx;
        idx = 0;
        if (exp_pkt[port].size() == 0) begin
            fail_msg($sformatf("packet %h left port %s but none was expected", act, port_nm[port]));
            return;
        end
        if (rnd_mode) begin                        // Sources interleave but each keeps its order
            idx = -1;
            for (int i = 0; i < exp_pkt[port].size(); i++)
                if (idx < 0 && exp_pkt[port][i] == act) idx = i;
            if (idx < 0) idx = 0;
            for (int j = 0; j < idx; j++)
                if (exp_chan[port][j] == exp_chan[port][idx])
                    fail_msg($sformatf("packet %h overtook an older one from its input", act));
        end else if (test_mode == 0 && cyc - exp_acc[port][0] != 2) begin
            fail_msg($sformatf("latency on %s was %0d cycles", port_nm[port],
                               cyc - exp_acc[port][0]));
        end
        check_pkt(exp_pkt[port][idx], act, port_nm[port]);
        exp_pkt[port].delete(idx);
        exp_chan[port].delete(idx);
        exp_ord[port].delete(idx);
        exp_acc[port].delete(idx);
    endtask

    always @(negedge clk) begin
        logic [2:0] rdy;
        if (rnd_mode) begin
            for (int k = 0; k < 3; k++) begin
                lfsr = lfsr_step(lfsr);            // One step per ready bit
                rdy[k] = lfsr[0];
            end
        end else begin
            rdy = {2'b11, ~hold_x};
        end
        x_ready_i = rdy[0];
        y_ready_i = rdy[1];
        b_ready_i = rdy[2];
        #(CLK_NS / 4);                             // Sample in the middle of the low phase
        if (rst_n) begin
            if (x_valid_o && rdy[0]) take_output(0, x_pkt_o);
            if (y_valid_o && rdy[1]) take_output(1, y_pkt_o);
            if (b_valid_o && rdy[2]) take_output(2, b_pkt_o);
            if (cfg_ack_o && !ack_prev && !cfg_req_i) fail_msg("ack rose without a request");
            if (!cfg_ack_o && ack_prev && cfg_req_i) fail_msg("ack fell while req was high");
        end
        ack_prev = cfg_ack_o;
    end

    // ========================================
    // Drivers
    // ========================================
    task automatic drive_chan(input int ch, input logic v, input pkt_t p);
        case (ch)
            0: begin a_valid_i = v; a_pkt_i = p; end
            1: begin cx_valid_i = v; cx_pkt_i = p; end
            default: begin cy_valid_i = v; cy_pkt_i = p; end
        endcase
    endtask

    task automatic send_pkt(input int ch, input pkt_t p, output int acc, output route_e rt);
        int waited;
        @(negedge clk);
        drive_chan(ch, 1'b1, p);
        waited = 0;
        #(CLK_NS / 4);
        while (!(ch == 0 ? a_ready_o : ch == 1 ? cx_ready_o : cy_ready_o)) begin
            if (waited++ > STALL_LIMIT) break;
            @(negedge clk);
            #(CLK_NS / 4);
        end
        if (waited > STALL_LIMIT) fail_msg("input never became ready");
        acc = cyc;                                 // Transfer on the coming rising edge
        @(negedge clk);
        drive_chan(ch, 1'b0, p);
        #(CLK_NS / 4);
        rt = slot_route(ch);                       // Slot holds the packet until the next edge
    endtask

    task automatic wait_ack(input logic level);
        int waited;
        waited = 0;
        #(CLK_NS / 4);
        while (cfg_ack_o !== level && waited++ < STALL_LIMIT) begin
            @(negedge clk);
            #(CLK_NS / 4);
        end
        if (cfg_ack_o !== level) fail_msg($sformatf("cfg ack never went to %b", level));
    endtask

    task automatic write_cfg(input cfg_addr_e op, input node_id_t wd);
        @(negedge clk);
        if (cfg_ack_o) fail_msg("cfg ack high before the request");
        cfg_req_i = 1'b1;
        cfg_addr_i = op;
        cfg_wdata_i = wd;
        wait_ack(1'b1);
        @(negedge clk);
        cfg_req_i = 1'b0;                          // Phase 3 drops req and ack must follow
        wait_ack(1'b0);
        case (op)
            CFG_NODE_ID: m_node = wd;
            CFG_FAULT_SET: begin m_fault = wd; m_fault_en = 1'b1; end
            default: m_fault_en = 1'b0;
        endcase
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_pkt[0].size() + exp_pkt[1].size() + exp_pkt[2].size() != 0
               && waited++ < STALL_LIMIT) @(negedge clk);
        for (int k = 0; k < 3; k++) begin
            if (exp_pkt[k].size() != 0)
                fail_msg($sformatf("%0d packets never left port %s", exp_pkt[k].size(), port_nm[k]));
            exp_pkt[k].delete();
            exp_chan[k].delete();
            exp_ord[k].delete();
            exp_acc[k].delete();
        end
        repeat (4) @(negedge clk);                 // Strays from dropped packets show up here
    endtask

    task automatic run_item(input int k);
        pkt_t p;
        route_e r;
        route_e dut_r;
        int ch, acc, pos;
        ch = (it_chan[k] == "A") ? 0 : (it_chan[k] == "CX") ? 1 : (it_chan[k] == "CY") ? 2 : 3;
        if (ch == 3) begin
            drain_outputs();                       // Configure only with nothing in flight
            write_cfg(cfg_addr_e'(it_type[k][1:0]), it_tgt[k]);
            return;
        end
        p = {pkt_type_e'(it_type[k][1:0]), it_qos[k][0], it_src[k], it_tgt[k], it_data[k]};
        r = ref_route(ch, p);
        send_pkt(ch, p, acc, dut_r);
        check_route(parse_route(it_route[k]), dut_r);
        if (r == ROUTE_DROP) return;
        pos = exp_pkt[r].size();
        for (int i = 0; i < exp_ord[r].size(); i++)
            if (pos == exp_pkt[r].size() && exp_ord[r][i] > it_ord[k]) pos = i;
        exp_pkt[r].insert(pos, p);                 // Kept in expected leave order
        exp_chan[r].insert(pos, ch);
        exp_ord[r].insert(pos, it_ord[k]);
        exp_acc[r].insert(pos, acc);
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin
        int i, err_before, n_tests, n_failed;
        {rst_n, cfg_req_i, a_valid_i, cx_valid_i, cy_valid_i} = '0;
        {x_ready_i, y_ready_i, b_ready_i} = 3'b111;
        cfg_addr_i = CFG_NODE_ID;
        cfg_wdata_i = '0;
        {a_pkt_i, cx_pkt_i, cy_pkt_i} = '0;
        load_items();
        if (n_items == 0) fail_msg("no stimulus read from verif/node_input.dat");
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        #(CLK_NS / 4);
        if (cfg_ack_o || x_valid_o || y_valid_o || b_valid_o) fail_msg("outputs high after reset");
        if (!(a_ready_o && cx_ready_o && cy_ready_o)) fail_msg("inputs not ready after reset");
        i = 0;
        n_tests = 0;
        n_failed = 0;
        while (i < n_items) begin
            cur_test = it_name[i];
            err_before = err_count;
            test_mode = it_mode[i];
            rnd_mode = (test_mode == 2);
            hold_x = (test_mode == 1);             // X held off while the slots fill
            while (i < n_items && it_name[i] == cur_test) run_item(i++);
            hold_x = 1'b0;
            drain_outputs();
            rnd_mode = 1'b0;
            n_tests++;
            if (err_count != err_before) n_failed++;
            $display("test %s %s", cur_test, (err_count == err_before) ? "ok" : "FAILED");
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (n_items > 0);
        #(n_items * 200 * CLK_NS);                 // 200 cycles per data line
        $display("timeout after %0d cycles in test %s", n_items * 200, cur_test);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: verif/node_input.dat
# test chan type qos src tgt data route ord mode  (hex src tgt data, CFG uses type as opcode)
# mode 0 ready high, 1 X held low then released, 2 random ready; ord is leave order per port
cfg_id    CFG 0 0 00 1C 00 - 0 0
eject     A   0 0 1C 1C 01 B 0 0
eject     CX  0 0 05 1C 02 B 1 0
eject     CY  0 1 2A 1C 03 B 2 0
two_hop   A   0 0 1C 29 10 X 0 0
two_hop   CFG 1 0 00 19 00 - 0 0
two_hop   A   0 0 1C 29 11 Y 1 0
two_hop   A   0 0 1C 0C 12 Y 2 0
two_hop   CFG 2 0 00 00 00 - 0 0
two_hop   A   0 0 1C 29 13 X 3 0
link_xy   CX  0 0 07 29 20 X 0 0
link_xy   CY  0 0 07 0C 21 Y 1 0
link_xy   CY  0 0 07 3A 22 X 2 0
link_xy   CX  0 0 07 24 23 Y 3 0
qos_rr    A   0 0 1C 19 30 X 0 1
qos_rr    CX  0 0 03 19 31 X 3 1
qos_rr    CY  0 1 04 19 32 X 1 1
qos_rr    A   0 0 1C 18 33 X 2 1
discard   A   1 0 1C 1C 40 DROP 0 0
discard   CX  2 0 05 29 41 DROP 0 0
discard   CY  1 1 06 0C 42 DROP 0 0
discard   A   0 0 1C 1C 43 B 0 0
backpress A   0 0 1C 29 50 X 0 2
backpress CX  0 0 05 1C 51 B 1 2
backpress CY  0 1 06 0C 52 Y 2 2
backpress A   0 0 1C 1C 53 B 3 2
backpress CX  0 0 05 29 54 X 4 2
backpress CY  0 0 06 3A 55 X 5 2
backpress A   0 0 1C 0C 56 Y 6 2
cfg_move  CFG 0 0 00 29 00 - 0 0
cfg_move  A   0 0 29 29 60 B 0 0
cfg_move  CX  0 0 05 1C 61 X 1 0

// File: vlog.f
logic/mesh_pkg.sv
logic/pkt_pkg.sv
logic/node_cfg.sv
logic/pkt_slot.sv
logic/route_calc.sv
logic/qos_out_port.sv
logic/mesh_node.sv
verif/mesh_node_tb.sv
